//--- axi_wmux.f
hw/axi_wmux_pkg.sv
hw/aw_chan_if.sv
hw/aw_rr_arbiter.sv
hw/w_steer.sv
hw/b_return.sv
hw/axi_wmux.sv
tests/tb_axi_wmux.sv

//--- hw/aw_chan_if.sv
// One arbitrated AW channel with valid/ready and the payload held stable while valid is high
`timescale 1ns/10ps
`default_nettype none

interface aw_chan_if #(
  parameter int unsigned IdWidth = 6  // Port index bits plus port ID bits
);

  logic [IdWidth-1:0]  id;    // Port index above the original ID
  axi_wmux_pkg::addr_t addr;
  axi_wmux_pkg::len_t  len;
  logic                valid;
  logic                ready;

  // Arbiter side
  modport src (
    output id,
    output addr,
    output len,
    output valid,
    input  ready
  );

  // Issue control side
  modport dst (
    input  id,
    input  addr,
    input  len,
    input  valid,
    output ready
  );

endinterface

`default_nettype wire

//--- hw/aw_rr_arbiter.sv
// Requesters must keep AW valid and payload stable until accepted and NumPorts is at least 2
`timescale 1ns/10ps
`default_nettype none

module aw_rr_arbiter #(
  parameter int unsigned NumPorts = 3
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic [NumPorts-1:0]                  req_valid_i,
  output logic [NumPorts-1:0]                  req_ready_o,
  input  axi_wmux_pkg::slv_id_t [NumPorts-1:0] req_id_i,
  input  axi_wmux_pkg::addr_t   [NumPorts-1:0] req_addr_i,
  input  axi_wmux_pkg::len_t    [NumPorts-1:0] req_len_i,
  aw_chan_if.src                               aw_o
);

  localparam int unsigned IdxWidth = $clog2(NumPorts);

  typedef logic [IdxWidth-1:0] idx_t;
  typedef logic [IdxWidth:0]   sum_t;  // One spare bit for the wrap check

  idx_t rr_ptr_q;    // Highest priority port
  idx_t lock_idx_q;  // Port held while its AW waits
  logic lock_q;
  idx_t search_idx;
  logic search_hit;
  idx_t sel_idx;
  logic xfer;

  // ---------------------------------------------------------------------------
  // First valid port at or after the pointer
  // ---------------------------------------------------------------------------
  always_comb begin : rr_search
    sum_t cand;
    search_idx = rr_ptr_q;
    search_hit = 1'b0;
    for (int unsigned k = 0; k < NumPorts; k++) begin
      cand = {1'b0, rr_ptr_q} + sum_t'(k);
      if (cand >= sum_t'(NumPorts)) begin
        cand = cand - sum_t'(NumPorts);  // Wrap around
      end
      if (!search_hit && req_valid_i[cand[IdxWidth-1:0]]) begin
        search_hit = 1'b1;
        search_idx = cand[IdxWidth-1:0];
      end
    end
  end

  // Lock-in keeps the grant steady until the offered AW is taken
  assign sel_idx = lock_q ? lock_idx_q : search_idx;

  // ---------------------------------------------------------------------------
  // Forward the chosen AW with its port index prepended
  // ---------------------------------------------------------------------------
  assign aw_o.valid = lock_q | search_hit;
  assign aw_o.id    = {sel_idx, req_id_i[sel_idx]};
  assign aw_o.addr  = req_addr_i[sel_idx];
  assign aw_o.len   = req_len_i[sel_idx];

  assign xfer = aw_o.valid & aw_o.ready;

  always_comb begin
    req_ready_o          = '0;
    req_ready_o[sel_idx] = xfer;  // Only the granted port sees ready
  end

  // ---------------------------------------------------------------------------
  // Pointer and lock state
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr_q   <= '0;
      lock_idx_q <= '0;
      lock_q     <= 1'b0;
    end else begin
      if (xfer) begin
        lock_q   <= 1'b0;
        // Next search starts one past the winner
        rr_ptr_q <= (sel_idx == idx_t'(NumPorts - 1)) ? '0 : sel_idx + 1'b1;
      end else if (aw_o.valid) begin
        lock_q     <= 1'b1;  // Offered but not taken
        lock_idx_q <= sel_idx;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/axi_wmux.sv
// Write path only with NumPorts of 2 or more and a master ID wider by the port index bits
`timescale 1ns/10ps
`default_nettype none

module axi_wmux #(
  parameter  int unsigned NumPorts   = 3,
  parameter  int unsigned MaxWTrans  = 4,
  localparam int unsigned MstIdWidth = axi_wmux_pkg::SlvIdWidth + $clog2(NumPorts)
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // ---------------------------------------------------------------------------
  // Requesting ports
  // ---------------------------------------------------------------------------
  input  logic [NumPorts-1:0]                  slv_aw_valid_i,
  output logic [NumPorts-1:0]                  slv_aw_ready_o,
  input  axi_wmux_pkg::slv_id_t [NumPorts-1:0] slv_aw_id_i,
  input  axi_wmux_pkg::addr_t   [NumPorts-1:0] slv_aw_addr_i,
  input  axi_wmux_pkg::len_t    [NumPorts-1:0] slv_aw_len_i,
  input  logic [NumPorts-1:0]                  slv_w_valid_i,
  output logic [NumPorts-1:0]                  slv_w_ready_o,
  input  axi_wmux_pkg::data_t   [NumPorts-1:0] slv_w_data_i,
  input  axi_wmux_pkg::strb_t   [NumPorts-1:0] slv_w_strb_i,
  input  logic [NumPorts-1:0]                  slv_w_last_i,
  output logic [NumPorts-1:0]                  slv_b_valid_o,
  input  logic [NumPorts-1:0]                  slv_b_ready_i,
  output axi_wmux_pkg::slv_id_t                slv_b_id_o,    // Shared by all ports
  output axi_wmux_pkg::resp_e                  slv_b_resp_o,
  // ---------------------------------------------------------------------------
  // Master port
  // ---------------------------------------------------------------------------
  output logic                                 mst_aw_valid_o,
  input  logic                                 mst_aw_ready_i,
  output logic [MstIdWidth-1:0]                mst_aw_id_o,
  output axi_wmux_pkg::addr_t                  mst_aw_addr_o,
  output axi_wmux_pkg::len_t                   mst_aw_len_o,
  output logic                                 mst_w_valid_o,
  input  logic                                 mst_w_ready_i,
  output axi_wmux_pkg::data_t                  mst_w_data_o,
  output axi_wmux_pkg::strb_t                  mst_w_strb_o,
  output logic                                 mst_w_last_o,
  input  logic                                 mst_b_valid_i,
  output logic                                 mst_b_ready_o,
  input  logic [MstIdWidth-1:0]                mst_b_id_i,
  input  axi_wmux_pkg::resp_e                  mst_b_resp_i
);

  // Granted AW between arbiter and issue control
  aw_chan_if #(.IdWidth(MstIdWidth)) aw_chan ();

  aw_rr_arbiter #(
    .NumPorts (NumPorts)
  ) u_aw_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (slv_aw_valid_i),
    .req_ready_o (slv_aw_ready_o),
    .req_id_i    (slv_aw_id_i),
    .req_addr_i  (slv_aw_addr_i),
    .req_len_i   (slv_aw_len_i),
    .aw_o        (aw_chan)
  );

  w_steer #(
    .NumPorts  (NumPorts),
    .MaxWTrans (MaxWTrans)
  ) u_w_steer (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .aw_i           (aw_chan),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .mst_aw_id_o    (mst_aw_id_o),
    .mst_aw_addr_o  (mst_aw_addr_o),
    .mst_aw_len_o   (mst_aw_len_o),
    .slv_w_valid_i  (slv_w_valid_i),
    .slv_w_ready_o  (slv_w_ready_o),
    .slv_w_data_i   (slv_w_data_i),
    .slv_w_strb_i   (slv_w_strb_i),
    .slv_w_last_i   (slv_w_last_i),
    .mst_w_valid_o  (mst_w_valid_o),
    .mst_w_data_o   (mst_w_data_o),
    .mst_w_strb_o   (mst_w_strb_o),
    .mst_w_last_o   (mst_w_last_o),
    .mst_w_ready_i  (mst_w_ready_i)
  );

  b_return #(
    .NumPorts (NumPorts)
  ) u_b_return (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .mst_b_valid_i (mst_b_valid_i),
    .mst_b_ready_o (mst_b_ready_o),
    .mst_b_id_i    (mst_b_id_i),
    .mst_b_resp_i  (mst_b_resp_i),
    .slv_b_valid_o (slv_b_valid_o),
    .slv_b_ready_i (slv_b_ready_i),
    .slv_b_id_o    (slv_b_id_o),
    .slv_b_resp_o  (slv_b_resp_o)
  );

endmodule

`default_nettype wire

//--- hw/axi_wmux_pkg.sv
// Fixed AXI write widths shared by all ports and no user, burst, size, cache or prot fields
`default_nettype none

package axi_wmux_pkg;

  // ---------------------------------------------------------------------------
  // Widths
  // ---------------------------------------------------------------------------
  localparam int unsigned SlvIdWidth = 4;   // ID width seen by each requesting port
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned DataWidth  = 32;
  localparam int unsigned LenWidth   = 8;   // AXI4 burst length field

  // ---------------------------------------------------------------------------
  // Channel field types
  // ---------------------------------------------------------------------------
  typedef logic [SlvIdWidth-1:0]  slv_id_t;
  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [DataWidth/8-1:0] strb_t;  // One strobe per byte lane
  typedef logic [LenWidth-1:0]    len_t;   // Beats minus one

  // Write response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  // AW issue control
  typedef enum logic {
    AW_OPEN   = 1'b0,  // New grants may go out
    AW_LOCKED = 1'b1   // Offered AW held until accepted
  } aw_state_e;

endpackage

`default_nettype wire

//--- hw/b_return.sv
// One registered B stage and the index bits of the B ID must name an existing port
`timescale 1ns/10ps
`default_nettype none

module b_return #(
  parameter  int unsigned NumPorts   = 3,
  localparam int unsigned MstIdWidth = axi_wmux_pkg::SlvIdWidth + $clog2(NumPorts)
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Master B
  input  logic                  mst_b_valid_i,
  output logic                  mst_b_ready_o,
  input  logic [MstIdWidth-1:0] mst_b_id_i,
  input  axi_wmux_pkg::resp_e   mst_b_resp_i,
  // Port B
  output logic [NumPorts-1:0]   slv_b_valid_o,
  input  logic [NumPorts-1:0]   slv_b_ready_i,
  output axi_wmux_pkg::slv_id_t slv_b_id_o,
  output axi_wmux_pkg::resp_e   slv_b_resp_o
);

  localparam int unsigned IdxWidth = $clog2(NumPorts);

  logic                  valid_q;
  logic [MstIdWidth-1:0] id_q;
  axi_wmux_pkg::resp_e   resp_q;
  logic [IdxWidth-1:0]   target;
  logic                  take;

  assign target = id_q[axi_wmux_pkg::SlvIdWidth +: IdxWidth];  // Port index bits
  assign take   = valid_q & slv_b_ready_i[target];

  // Accept when empty or when the held response leaves this cycle
  assign mst_b_ready_o = ~valid_q | take;

  // Shared payload, per-port valid
  assign slv_b_id_o   = id_q[axi_wmux_pkg::SlvIdWidth-1:0];
  assign slv_b_resp_o = resp_q;

  always_comb begin
    slv_b_valid_o         = '0;
    slv_b_valid_o[target] = valid_q;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (mst_b_valid_i && mst_b_ready_o) begin
      valid_q <= 1'b1;
    end else if (take) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mst_b_valid_i && mst_b_ready_o) begin
      id_q   <= mst_b_id_i;
      resp_q <= mst_b_resp_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/w_steer.sv
// W bursts must follow their AW order and up to MaxWTrans bursts may wait for their data
`timescale 1ns/10ps
`default_nettype none

module w_steer #(
  parameter  int unsigned NumPorts   = 3,
  parameter  int unsigned MaxWTrans  = 4,
  localparam int unsigned MstIdWidth = axi_wmux_pkg::SlvIdWidth + $clog2(NumPorts)
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  // Arbitrated AW
  aw_chan_if.dst                             aw_i,
  // Master AW
  output logic                               mst_aw_valid_o,
  input  logic                               mst_aw_ready_i,
  output logic [MstIdWidth-1:0]              mst_aw_id_o,
  output axi_wmux_pkg::addr_t                mst_aw_addr_o,
  output axi_wmux_pkg::len_t                 mst_aw_len_o,
  // Port W
  input  logic [NumPorts-1:0]                slv_w_valid_i,
  output logic [NumPorts-1:0]                slv_w_ready_o,
  input  axi_wmux_pkg::data_t [NumPorts-1:0] slv_w_data_i,
  input  axi_wmux_pkg::strb_t [NumPorts-1:0] slv_w_strb_i,
  input  logic [NumPorts-1:0]                slv_w_last_i,
  // Master W
  output logic                               mst_w_valid_o,
  output axi_wmux_pkg::data_t                mst_w_data_o,
  output axi_wmux_pkg::strb_t                mst_w_strb_o,
  output logic                               mst_w_last_o,
  input  logic                               mst_w_ready_i
);

  localparam int unsigned IdxWidth = $clog2(NumPorts);
  localparam int unsigned PtrWidth = (MaxWTrans > 1) ? $clog2(MaxWTrans) : 1;
  localparam int unsigned CntWidth = $clog2(MaxWTrans + 1);

  typedef logic [IdxWidth-1:0] idx_t;
  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  axi_wmux_pkg::aw_state_e state_q, state_d;

  idx_t fifo_mem [MaxWTrans];  // Port order of accepted AWs
  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  cnt_t count_q;
  logic fifo_full;
  logic fifo_empty;
  logic fifo_push;
  logic fifo_pop;
  idx_t head;

  assign fifo_full  = (count_q == cnt_t'(MaxWTrans));
  assign fifo_empty = (count_q == '0);
  assign head       = fifo_mem[rd_ptr_q];

  // ---------------------------------------------------------------------------
  // AW issue control
  // ---------------------------------------------------------------------------
  assign mst_aw_id_o   = aw_i.id;
  assign mst_aw_addr_o = aw_i.addr;
  assign mst_aw_len_o  = aw_i.len;

  always_comb begin
    state_d        = state_q;
    fifo_push      = 1'b0;
    mst_aw_valid_o = 1'b0;
    aw_i.ready     = 1'b0;
    case (state_q)
      axi_wmux_pkg::AW_LOCKED: begin
        mst_aw_valid_o = 1'b1;  // Arbiter holds the same AW
        if (mst_aw_ready_i) begin
          aw_i.ready = 1'b1;
          fifo_push  = 1'b1;
          state_d    = axi_wmux_pkg::AW_OPEN;
        end
      end
      default: begin
        if (!fifo_full) begin  // Stall new AWs while no decision slot is free
          aw_i.ready = mst_aw_ready_i;
          if (aw_i.valid) begin
            mst_aw_valid_o = 1'b1;
            if (mst_aw_ready_i) begin
              fifo_push = 1'b1;
            end else begin
              state_d = axi_wmux_pkg::AW_LOCKED;
            end
          end
        end
      end
    endcase
  end

  // ---------------------------------------------------------------------------
  // Decision FIFO
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= axi_wmux_pkg::AW_OPEN;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      state_q <= state_d;
      if (fifo_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(MaxWTrans - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (fifo_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(MaxWTrans - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({fifo_push, fifo_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifo_push) begin
      fifo_mem[wr_ptr_q] <= aw_i.id[axi_wmux_pkg::SlvIdWidth +: IdxWidth];
    end
  end

  // ---------------------------------------------------------------------------
  // W multiplexer
  // ---------------------------------------------------------------------------
  assign mst_w_data_o = slv_w_data_i[head];
  assign mst_w_strb_o = slv_w_strb_i[head];
  assign mst_w_last_o = slv_w_last_i[head];

  always_comb begin
    mst_w_valid_o = 1'b0;
    slv_w_ready_o = '0;
    fifo_pop      = 1'b0;
    if (!fifo_empty) begin
      // Only the port at the head is connected
      mst_w_valid_o       = slv_w_valid_i[head];
      slv_w_ready_o[head] = mst_w_ready_i;
      fifo_pop            = slv_w_valid_i[head] & mst_w_ready_i & slv_w_last_i[head];
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_axi_wmux \
  -f axi_wmux.f -o tb_axi_wmux > build.log 2>&1 \
  && ./obj_dir/tb_axi_wmux > sim.log 2>&1 \
  && grep -q "All checks passed" sim.log \
  && echo "Simulation PASS" \
  || { echo "Simulation FAIL, see build.log and sim.log"; exit 1; }

//--- tests/tb_axi_wmux.sv
// Directed checks with three ports and FIFO depth four, inputs driven on rising edges
`timescale 1ns/10ps
`default_nettype none

module tb_axi_wmux;

  localparam int unsigned NumPorts   = 3;
  localparam int unsigned MaxWTrans  = 4;
  localparam int unsigned MstIdWidth = axi_wmux_pkg::SlvIdWidth + $clog2(NumPorts);
  localparam int unsigned TestCycles = 1 + 7 + 6 + 6 + 8 + 10 + 9;  // Per test in run order

  typedef logic [MstIdWidth-1:0] mst_id_t;
  typedef logic [NumPorts-1:0]   mask_t;

  logic clk_i;
  logic rst_n_i;
  mask_t                                slv_aw_valid_i, slv_aw_ready_o;
  axi_wmux_pkg::slv_id_t [NumPorts-1:0] slv_aw_id_i;
  axi_wmux_pkg::addr_t   [NumPorts-1:0] slv_aw_addr_i;
  axi_wmux_pkg::len_t    [NumPorts-1:0] slv_aw_len_i;
  mask_t                                slv_w_valid_i, slv_w_ready_o, slv_w_last_i;
  axi_wmux_pkg::data_t   [NumPorts-1:0] slv_w_data_i;
  axi_wmux_pkg::strb_t   [NumPorts-1:0] slv_w_strb_i;
  mask_t                                slv_b_valid_o, slv_b_ready_i;
  axi_wmux_pkg::slv_id_t                slv_b_id_o;
  axi_wmux_pkg::resp_e                  slv_b_resp_o, mst_b_resp_i;
  logic                                 mst_aw_valid_o, mst_aw_ready_i;
  mst_id_t                              mst_aw_id_o, mst_b_id_i;
  axi_wmux_pkg::addr_t                  mst_aw_addr_o;
  axi_wmux_pkg::len_t                   mst_aw_len_o;
  logic                                 mst_w_valid_o, mst_w_ready_i, mst_w_last_o;
  axi_wmux_pkg::data_t                  mst_w_data_o;
  axi_wmux_pkg::strb_t                  mst_w_strb_o;
  logic                                 mst_b_valid_i, mst_b_ready_o;

  int unsigned errors;
  logic [15:0] lfsr_q;

  axi_wmux #(.NumPorts(NumPorts), .MaxWTrans(MaxWTrans)) u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------------
  // Galois LFSR x^16 + x^14 + x^13 + x^11 + 1 with one output bit per step
  function automatic logic lfsr_step();
    logic out_bit;
    out_bit = lfsr_q[0];
    lfsr_q  = lfsr_q >> 1;
    if (out_bit) begin
      lfsr_q = lfsr_q ^ 16'hB400;
    end
    return out_bit;
  endfunction

  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  // Port index goes above the port's own ID bits
  function automatic mst_id_t widen_id(int unsigned port, axi_wmux_pkg::slv_id_t id);
    return (mst_id_t'(port) << axi_wmux_pkg::SlvIdWidth) | mst_id_t'(id);
  endfunction

  task automatic set_idle();
    slv_aw_valid_i <= '0;
    slv_aw_id_i    <= '0;
    slv_aw_addr_i  <= '0;
    slv_aw_len_i   <= '0;
    slv_w_valid_i  <= '0;
    slv_w_data_i   <= '0;
    slv_w_strb_i   <= '0;
    slv_w_last_i   <= '0;
    slv_b_ready_i  <= '1;
    mst_aw_ready_i <= 1'b1;
    mst_w_ready_i  <= 1'b1;
    mst_b_valid_i  <= 1'b0;
    mst_b_id_i     <= '0;
    mst_b_resp_i   <= axi_wmux_pkg::RESP_OKAY;
  endtask

  task automatic apply_reset();
    rst_n_i <= 1'b0;
    set_idle();
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
  endtask

  // ----------------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------------
  task automatic check_id(string name, mst_id_t exp, mst_id_t act);
    if (exp !== act) begin
      errors++;
      $display("ERROR %s id expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_addr(string name, axi_wmux_pkg::addr_t exp, axi_wmux_pkg::addr_t act);
    if (exp !== act) begin
      errors++;
      $display("ERROR %s addr expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_len(string name, axi_wmux_pkg::len_t exp, axi_wmux_pkg::len_t act);
    if (exp !== act) begin
      errors++;
      $display("ERROR %s len expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_data(string name, axi_wmux_pkg::data_t exp, axi_wmux_pkg::data_t act);
    if (exp !== act) begin
      errors++;
      $display("ERROR %s data expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_strb(string name, axi_wmux_pkg::strb_t exp, axi_wmux_pkg::strb_t act);
    if (exp !== act) begin
      errors++;
      $display("ERROR %s strb expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_resp(string name, axi_wmux_pkg::resp_e exp, axi_wmux_pkg::resp_e act);
    if (exp !== act) begin
      errors++;
      $display("ERROR %s resp expected %s actual %s", name, exp.name(), act.name());
    end
  endtask

  // Per-port handshake vectors and single flags
  task automatic check_bits(string name, mask_t exp, mask_t act);
    if (exp !== act) begin
      errors++;
      $display("ERROR %s flags expected %b actual %b", name, exp, act);
    end
  endtask

  // ----------------------------------------------------------------------------
  // Transaction tasks entered and left right after a rising edge
  // ----------------------------------------------------------------------------
  task automatic issue_aw(string name, int unsigned port, axi_wmux_pkg::len_t len);
    axi_wmux_pkg::slv_id_t id;
    axi_wmux_pkg::addr_t   addr;
    int unsigned           waited;
    id     = axi_wmux_pkg::slv_id_t'(rand_bits(4));
    addr   = rand_bits(32);
    waited = 0;
    slv_aw_valid_i[port] <= 1'b1;
    slv_aw_id_i[port]    <= id;
    slv_aw_addr_i[port]  <= addr;
    slv_aw_len_i[port]   <= len;
    @(negedge clk_i);
    while (!slv_aw_ready_o[port] && waited < 20) begin
      waited++;
      @(negedge clk_i);
    end
    if (!slv_aw_ready_o[port]) begin
      errors++;
      $display("%s: the AW of port %0d was never accepted", name, port);
    end
    check_bits(name, mask_t'(1), mask_t'(mst_aw_valid_o));
    check_id(name, widen_id(port, id), mst_aw_id_o);
    check_addr(name, addr, mst_aw_addr_o);
    check_len(name, len, mst_aw_len_o);
    @(posedge clk_i);
    slv_aw_valid_i[port] <= 1'b0;
  endtask

  task automatic send_burst(string name, int unsigned port, int unsigned beats);
    axi_wmux_pkg::data_t data;
    axi_wmux_pkg::strb_t strb;
    int unsigned         waited;
    for (int unsigned i = 0; i < beats; i++) begin
      data   = rand_bits(32);
      strb   = axi_wmux_pkg::strb_t'(rand_bits(4));
      waited = 0;
      slv_w_valid_i[port] <= 1'b1;
      slv_w_data_i[port]  <= data;
      slv_w_strb_i[port]  <= strb;
      slv_w_last_i[port]  <= (i == beats - 1);
      @(negedge clk_i);
      while (!(mst_w_valid_o && mst_w_ready_i) && waited < 20) begin
        waited++;
        @(negedge clk_i);
      end
      if (!mst_w_valid_o) begin
        errors++;
        $display("%s: a W beat of port %0d never reached the master", name, port);
      end
      check_data(name, data, mst_w_data_o);
      check_strb(name, strb, mst_w_strb_o);
      check_bits(name, mask_t'(i == beats - 1), mask_t'(mst_w_last_o));
      check_bits(name, mask_t'(1) << port, slv_w_ready_o);
      @(posedge clk_i);
    end
    slv_w_valid_i[port] <= 1'b0;
    slv_w_last_i[port]  <= 1'b0;
  endtask

  // ----------------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------------
  task automatic single_write();
    axi_wmux_pkg::slv_id_t bid;
    apply_reset();
    issue_aw("single_write", 1, 8'd1);
    send_burst("single_write", 1, 2);
    bid = axi_wmux_pkg::slv_id_t'(rand_bits(4));
    mst_b_valid_i <= 1'b1;
    mst_b_id_i    <= widen_id(1, bid);
    mst_b_resp_i  <= axi_wmux_pkg::RESP_SLVERR;
    @(negedge clk_i);
    check_bits("single_write", mask_t'(1), mask_t'(mst_b_ready_o));
    @(posedge clk_i);
    mst_b_valid_i <= 1'b0;
    @(negedge clk_i);  // One cycle through the B stage
    check_bits("single_write", mask_t'(3'b010), slv_b_valid_o);
    check_id("single_write", mst_id_t'(bid), mst_id_t'(slv_b_id_o));
    check_resp("single_write", axi_wmux_pkg::RESP_SLVERR, slv_b_resp_o);
    @(posedge clk_i);
  endtask

  task automatic round_robin();
    axi_wmux_pkg::slv_id_t ids [NumPorts];
    int unsigned           order [4];
    order = '{0, 1, 2, 0};
    apply_reset();
    for (int unsigned p = 0; p < NumPorts; p++) begin
      ids[p] = axi_wmux_pkg::slv_id_t'(rand_bits(4));
      slv_aw_valid_i[p] <= 1'b1;
      slv_aw_id_i[p]    <= ids[p];
      slv_aw_addr_i[p]  <= rand_bits(32);
    end
    for (int unsigned i = 0; i < 4; i++) begin
      @(negedge clk_i);
      check_bits("round_robin", mask_t'(1) << order[i], slv_aw_ready_o);
      check_id("round_robin", widen_id(order[i], ids[order[i]]), mst_aw_id_o);
      @(posedge clk_i);
    end
    slv_aw_valid_i <= '0;
  endtask

  task automatic aw_hold();
    axi_wmux_pkg::slv_id_t id;
    axi_wmux_pkg::addr_t   addr;
    id   = axi_wmux_pkg::slv_id_t'(rand_bits(4));
    addr = rand_bits(32);
    apply_reset();
    mst_aw_ready_i    <= 1'b0;
    slv_aw_valid_i    <= mask_t'(3'b100);  // Port 2 asks alone first
    slv_aw_id_i[2]    <= id;
    slv_aw_addr_i[2]  <= addr;
    slv_aw_len_i[2]   <= 8'd3;
    slv_aw_id_i[0]    <= ~id;
    slv_aw_addr_i[0]  <= rand_bits(32);
    repeat (3) begin
      @(negedge clk_i);
      check_bits("aw_hold", mask_t'(1), mask_t'(mst_aw_valid_o));
      check_id("aw_hold", widen_id(2, id), mst_aw_id_o);
      check_addr("aw_hold", addr, mst_aw_addr_o);
      check_len("aw_hold", 8'd3, mst_aw_len_o);
      check_bits("aw_hold", '0, slv_aw_ready_o);
      @(posedge clk_i);
      slv_aw_valid_i[0] <= 1'b1;  // Port 0 outranks port 2 but must not take the grant
    end
    mst_aw_ready_i <= 1'b1;
    @(negedge clk_i);
    check_bits("aw_hold", mask_t'(3'b100), slv_aw_ready_o);
    check_id("aw_hold", widen_id(2, id), mst_aw_id_o);
    @(posedge clk_i);
    slv_aw_valid_i <= '0;
  endtask

  task automatic w_order();
    axi_wmux_pkg::data_t data [NumPorts];
    int unsigned         order [NumPorts];
    order = '{2, 0, 1};
    apply_reset();
    for (int unsigned i = 0; i < NumPorts; i++) begin
      issue_aw("w_order", order[i], '0);
    end
    for (int unsigned p = 0; p < NumPorts; p++) begin
      data[p] = rand_bits(32);
      slv_w_valid_i[p] <= 1'b1;
      slv_w_data_i[p]  <= data[p];
      slv_w_strb_i[p]  <= 4'hF;
      slv_w_last_i[p]  <= 1'b1;
    end
    for (int unsigned i = 0; i < NumPorts; i++) begin
      @(negedge clk_i);
      check_bits("w_order", mask_t'(1), mask_t'(mst_w_valid_o));
      check_data("w_order", data[order[i]], mst_w_data_o);
      check_bits("w_order", mask_t'(1) << order[i], slv_w_ready_o);
      @(posedge clk_i);
      slv_w_valid_i[order[i]] <= 1'b0;
    end
  endtask

  task automatic outstanding_limit();
    axi_wmux_pkg::slv_id_t id;
    apply_reset();
    mst_w_ready_i <= 1'b0;
    for (int unsigned i = 0; i < MaxWTrans; i++) begin
      issue_aw("outstanding_limit", i % NumPorts, '0);
    end
    id = axi_wmux_pkg::slv_id_t'(rand_bits(4));
    slv_aw_valid_i[1] <= 1'b1;
    slv_aw_id_i[1]    <= id;
    slv_aw_len_i[1]   <= '0;
    repeat (2) begin
      @(negedge clk_i);  // Decision FIFO full
      check_bits("outstanding_limit", '0, mask_t'(mst_aw_valid_o));
      check_bits("outstanding_limit", '0, slv_aw_ready_o);
      @(posedge clk_i);
    end
    mst_w_ready_i <= 1'b1;
    send_burst("outstanding_limit", 0, 1);
    @(negedge clk_i);
    check_bits("outstanding_limit", mask_t'(1), mask_t'(mst_aw_valid_o));
    check_id("outstanding_limit", widen_id(1, id), mst_aw_id_o);
    check_bits("outstanding_limit", mask_t'(3'b010), slv_aw_ready_o);
    @(posedge clk_i);
    slv_aw_valid_i <= '0;
  endtask

  task automatic b_backpressure();
    axi_wmux_pkg::slv_id_t bid0;
    axi_wmux_pkg::slv_id_t bid1;
    bid0 = axi_wmux_pkg::slv_id_t'(rand_bits(4));
    bid1 = axi_wmux_pkg::slv_id_t'(rand_bits(4));
    apply_reset();
    slv_b_ready_i <= mask_t'(3'b011);  // Port 2 stalls
    mst_b_valid_i <= 1'b1;
    mst_b_id_i    <= widen_id(2, bid0);
    mst_b_resp_i  <= axi_wmux_pkg::RESP_OKAY;
    @(negedge clk_i);
    check_bits("b_backpressure", mask_t'(1), mask_t'(mst_b_ready_o));
    @(posedge clk_i);
    mst_b_id_i   <= widen_id(0, bid1);
    mst_b_resp_i <= axi_wmux_pkg::RESP_EXOKAY;
    repeat (2) begin
      @(negedge clk_i);
      check_bits("b_backpressure", mask_t'(3'b100), slv_b_valid_o);
      check_id("b_backpressure", mst_id_t'(bid0), mst_id_t'(slv_b_id_o));
      check_resp("b_backpressure", axi_wmux_pkg::RESP_OKAY, slv_b_resp_o);
      check_bits("b_backpressure", '0, mask_t'(mst_b_ready_o));
      @(posedge clk_i);
    end
    slv_b_ready_i <= '1;
    @(negedge clk_i);
    check_bits("b_backpressure", mask_t'(1), mask_t'(mst_b_ready_o));
    @(posedge clk_i);
    mst_b_valid_i <= 1'b0;
    @(negedge clk_i);
    check_bits("b_backpressure", mask_t'(3'b001), slv_b_valid_o);
    check_id("b_backpressure", mst_id_t'(bid1), mst_id_t'(slv_b_id_o));
    check_resp("b_backpressure", axi_wmux_pkg::RESP_EXOKAY, slv_b_resp_o);
    @(posedge clk_i);
    @(negedge clk_i);
    check_bits("b_backpressure", '0, slv_b_valid_o);
    @(posedge clk_i);
  endtask

  // ----------------------------------------------------------------------------
  // Watchdog and main sequence
  // ----------------------------------------------------------------------------
  initial begin : watchdog
    repeat (TestCycles * 4) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d cycles", TestCycles * 4);
    $display("Checks failed");
    $finish;
  end

  initial begin
    errors  = 0;
    lfsr_q  = 16'd71;
    rst_n_i <= 1'b0;
    set_idle();
    @(posedge clk_i);
    single_write();
    round_robin();
    aw_hold();
    w_order();
    outstanding_limit();
    b_backpressure();
    $display("Summary: %0d errors", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
